/* f2_bus.f */
rtl/f2_bus_pkg.sv
rtl/cpu_addr_decode.sv
rtl/sdram_cpu_bridge.sv
rtl/irq_controller.sv
rtl/cpu_read_mux.sv
rtl/f2_bus_controller.sv
testbench/f2_bus_checker.sv
testbench/tb_f2_bus_controller.sv

/* f2_bus_tests.txt */
# kind addr strobes data expected, hex; strobes are {uds_n, lds_n}
# read data holds the inputs {joystick_p1, joystick_p2, start, coin, dswa, dswb}
# write expected is the SDRAM byte address, 0 when no request is made
# vbl, dma and iack expected is ipl_n
read  001234 0 0         edcb
read  0abcde 0 0         4321
write 100a40 1 a500      0100a40
read  100a40 0 0         f5bf
write 10fffe 2 005a      010fffe
read  10fffe 0 0         0001
write 300000 0 1234      0
write 200000 0 5678      0
read  300000 2 5a3c612fe 00ed
read  300002 2 5a3c612fe 0001
read  300004 2 5a3c612fe 002a
read  300006 2 5a3c612fe 00cc
read  300008 2 5a3c612fe 00f7
read  300004 2 0         00ff
read  200000 0 0         0000
vbl   000000 3 0         2
dma   000000 3 0         1
iack  00000c 2 0         2
iack  00000a 2 0         7

/* rtl/cpu_addr_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_addr_decode (
    input  wire                       clk,
    input  wire                       reset,
    input  wire f2_bus_pkg::cpu_bus_t cpu,
    output f2_bus_pkg::region_t       region,
    output logic                      cycle_start,
    output logic                      irq_ack,
    output logic [2:0]                irq_ack_level
);
    import f2_bus_pkg::*;

    logic ds_idle_q;
    logic strobe;
    logic cpu_space;

    // Offset wraps for addresses below the base
    function automatic logic in_range(
        input logic [CPU_ADDR_W-1:0] addr,
        input logic [CPU_ADDR_W-1:0] base,
        input logic [CPU_ADDR_W-1:0] size
    );
        logic [CPU_ADDR_W-1:0] offset;
        offset = addr - base;
        return offset < size;
    endfunction

    assign strobe    = ~&cpu.ds_n;
    assign cpu_space = cpu.fc == FC_IACK;

    ////////////////////////////////////////////////////////////
    // Region select

    always_comb begin
        region = '0;
        if (cpu_space) begin
            region.none = 1'b1;
        end else if (in_range(cpu.addr, ROM_BASE, ROM_SIZE)) begin
            region.rom = 1'b1;
        end else if (in_range(cpu.addr, WORK_BASE, WORK_SIZE)) begin
            region.work = 1'b1;
        end else if (in_range(cpu.addr, IO_BASE, IO_SIZE)) begin
            region.io = 1'b1;
        end else begin
            region.none = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Cycle start

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_idle_q <= 1'b1;
        end else begin
            ds_idle_q <= ~strobe;
        end
    end

    // First edge with a strobe low after both were high
    assign cycle_start = ds_idle_q & strobe;

    // Acknowledged level sits on A3..A1
    assign irq_ack       = cpu_space & ~cpu.ds_n[0];
    assign irq_ack_level = cpu.addr[3:1];

endmodule

`default_nettype wire

/* rtl/cpu_read_mux.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_read_mux (
    input  wire f2_bus_pkg::cpu_bus_t       cpu,
    input  wire f2_bus_pkg::region_t        region,
    input  wire f2_bus_pkg::player_inputs_t inputs,
    input  wire [15:0]                      sdr_q,
    input  wire                             sdr_busy,
    output logic [15:0]                     rdata,
    output logic                            dtack_n
);
    logic [7:0] p1_byte;
    logic [7:0] p2_byte;
    logic [7:0] io_byte;
    logic       strobe;
    logic       sdr_region;

    // Player port wiring, directions reversed
    assign p1_byte = {inputs.start[0], inputs.joystick_p1[6:4],
                      inputs.joystick_p1[0], inputs.joystick_p1[1],
                      inputs.joystick_p1[2], inputs.joystick_p1[3]};
    assign p2_byte = {inputs.start[1], inputs.joystick_p2[6:4],
                      inputs.joystick_p2[0], inputs.joystick_p2[1],
                      inputs.joystick_p2[2], inputs.joystick_p2[3]};

    // Active high here, inverted on the way out
    always_comb begin
        case (cpu.addr[3:1])
            3'd0:    io_byte = inputs.dswa;
            3'd1:    io_byte = inputs.dswb;
            3'd2:    io_byte = p1_byte;
            3'd3:    io_byte = p2_byte;
            3'd4:    io_byte = {4'b0000, inputs.coin, 2'b00};
            default: io_byte = 8'h00;
        endcase
    end

    assign sdr_region = region.rom | region.work;

    always_comb begin
        if (sdr_region) begin
            rdata = sdr_q;
        end else if (region.io) begin
            rdata = {8'h00, ~io_byte};
        end else begin
            rdata = 16'h0000;
        end
    end

    ////////////////////////////////////////////////////////////
    // Data acknowledge

    assign strobe  = ~&cpu.ds_n;
    assign dtack_n = ~(strobe & (~sdr_region | ~sdr_busy));

endmodule

`default_nettype wire

/* rtl/f2_bus_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module f2_bus_controller (
    input  wire                             clk,
    input  wire                             reset,
    input  wire f2_bus_pkg::cpu_bus_t       cpu,
    input  wire f2_bus_pkg::player_inputs_t inputs,
    input  wire                             vblank_n,
    input  wire                             dma_n,
    output f2_bus_pkg::sdr_req_t            sdr,
    input  wire [15:0]                      sdr_q,
    input  wire                             sdr_ack,
    output logic [15:0]                     cpu_rdata,
    output logic                            dtack_n,
    output logic [2:0]                      ipl_n
);
    import f2_bus_pkg::*;

    region_t    region;
    logic       cycle_start;
    logic       irq_ack;
    logic [2:0] irq_ack_level;
    logic       sdr_busy;

    cpu_addr_decode cpu_addr_decode_inst (
        .clk           (clk),
        .reset         (reset),
        .cpu           (cpu),
        .region        (region),
        .cycle_start   (cycle_start),
        .irq_ack       (irq_ack),
        .irq_ack_level (irq_ack_level)
    );

    sdram_cpu_bridge sdram_cpu_bridge_inst (
        .clk         (clk),
        .reset       (reset),
        .cpu         (cpu),
        .region      (region),
        .cycle_start (cycle_start),
        .sdr         (sdr),
        .sdr_ack     (sdr_ack),
        .sdr_busy    (sdr_busy)
    );

    irq_controller irq_controller_inst (
        .clk           (clk),
        .reset         (reset),
        .vblank_n      (vblank_n),
        .dma_n         (dma_n),
        .irq_ack       (irq_ack),
        .irq_ack_level (irq_ack_level),
        .ipl_n         (ipl_n)
    );

    cpu_read_mux cpu_read_mux_inst (
        .cpu      (cpu),
        .region   (region),
        .inputs   (inputs),
        .sdr_q    (sdr_q),
        .sdr_busy (sdr_busy),
        .rdata    (cpu_rdata),
        .dtack_n  (dtack_n)
    );

endmodule

`default_nettype wire

/* rtl/f2_bus_pkg.sv */
`default_nettype none

package f2_bus_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and memory map

    localparam int CPU_ADDR_W = 24;
    localparam int SDR_ADDR_W = 27;

    // CPU side, byte addresses
    localparam logic [CPU_ADDR_W-1:0] ROM_BASE  = 24'h000000;
    localparam logic [CPU_ADDR_W-1:0] ROM_SIZE  = 24'h100000;
    localparam logic [CPU_ADDR_W-1:0] WORK_BASE = 24'h100000;
    localparam logic [CPU_ADDR_W-1:0] WORK_SIZE = 24'h010000;
    localparam logic [CPU_ADDR_W-1:0] IO_BASE   = 24'h300000;
    localparam logic [CPU_ADDR_W-1:0] IO_SIZE   = 24'h000010;

    // Where the CPU regions sit in SDRAM
    localparam logic [SDR_ADDR_W-1:0] CPU_ROM_SDR_BASE  = 27'h0000000;
    localparam logic [SDR_ADDR_W-1:0] WORK_RAM_SDR_BASE = 27'h0100000;

    ////////////////////////////////////////////////////////////
    // Interrupts

    localparam logic [2:0] IRQ_LEVEL_VBL = 3'd5;
    localparam logic [2:0] IRQ_LEVEL_DMA = 3'd6;

    // CPU space, used for interrupt acknowledge
    localparam logic [2:0] FC_IACK = 3'b111;

    ////////////////////////////////////////////////////////////
    // Bus types

    typedef struct packed {
        logic [CPU_ADDR_W-1:0] addr;   // bit 0 always zero
        logic [1:0]            ds_n;   // {uds_n, lds_n}
        logic                  rw;     // 1 = read
        logic [2:0]            fc;
        logic [15:0]           wdata;
    } cpu_bus_t;

    typedef struct packed {
        logic rom;
        logic work;
        logic io;
        logic none;
    } region_t;

    typedef struct packed {
        logic [SDR_ADDR_W-1:0] addr;
        logic [15:0]           data;
        logic [1:0]            be;
        logic                  rw;
        logic                  req;    // toggles once per request
    } sdr_req_t;

    typedef struct packed {
        logic [7:0] joystick_p1;
        logic [7:0] joystick_p2;
        logic [1:0] start;
        logic [1:0] coin;
        logic [7:0] dswa;
        logic [7:0] dswb;
    } player_inputs_t;

endpackage

`default_nettype wire

/* rtl/irq_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module irq_controller (
    input  wire        clk,
    input  wire        reset,
    input  wire        vblank_n,
    input  wire        dma_n,
    input  wire        irq_ack,
    input  wire  [2:0] irq_ack_level,
    output logic [2:0] ipl_n
);
    import f2_bus_pkg::*;

    logic vbl_prev;
    logic dma_prev;
    logic vbl_event;
    logic dma_event;
    logic vbl_clear;
    logic dma_clear;
    logic vbl_pending;
    logic dma_pending;

    always_ff @(posedge clk) begin
        vbl_prev <= vblank_n;
        dma_prev <= dma_n;
    end

    // Falling vblank, rising DMA
    assign vbl_event = vbl_prev & ~vblank_n;
    assign dma_event = ~dma_prev & dma_n;

    assign vbl_clear = irq_ack & (irq_ack_level == IRQ_LEVEL_VBL);
    assign dma_clear = irq_ack & (irq_ack_level == IRQ_LEVEL_DMA);

    ////////////////////////////////////////////////////////////
    // Pending requests, clear beats set

    always_ff @(posedge clk) begin
        if (reset) begin
            vbl_pending <= 1'b0;
            dma_pending <= 1'b0;
        end else begin
            if (vbl_clear) begin
                vbl_pending <= 1'b0;
            end else if (vbl_event) begin
                vbl_pending <= 1'b1;
            end
            if (dma_clear) begin
                dma_pending <= 1'b0;
            end else if (dma_event) begin
                dma_pending <= 1'b1;
            end
        end
    end

    // DMA outranks vblank
    always_comb begin
        if (dma_pending) begin
            ipl_n = ~IRQ_LEVEL_DMA;
        end else if (vbl_pending) begin
            ipl_n = ~IRQ_LEVEL_VBL;
        end else begin
            ipl_n = 3'b111;
        end
    end

endmodule

`default_nettype wire

/* rtl/sdram_cpu_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module sdram_cpu_bridge (
    input  wire                       clk,
    input  wire                       reset,
    input  wire f2_bus_pkg::cpu_bus_t cpu,
    input  wire f2_bus_pkg::region_t  region,
    input  wire                       cycle_start,
    output f2_bus_pkg::sdr_req_t      sdr,
    input  wire                       sdr_ack,
    output logic                      sdr_busy
);
    import f2_bus_pkg::*;

    logic                  sdr_region;
    logic                  issue_q;
    logic                  req_q;
    logic [SDR_ADDR_W-1:0] next_addr;
    logic [SDR_ADDR_W-1:0] addr_q;
    logic [15:0]           data_q;
    logic [1:0]            be_q;
    logic                  rw_q;

    assign sdr_region = region.rom | region.work;

    // SDRAM byte address from the region base
    always_comb begin
        if (region.rom) begin
            next_addr = CPU_ROM_SDR_BASE
                      + {{(SDR_ADDR_W - CPU_ADDR_W){1'b0}}, cpu.addr};
        end else begin
            next_addr = WORK_RAM_SDR_BASE
                      + {{(SDR_ADDR_W - 16){1'b0}}, cpu.addr[15:0]};
        end
    end

    ////////////////////////////////////////////////////////////
    // Toggle request

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_q <= 1'b0;
            req_q   <= 1'b0;
        end else begin
            issue_q <= cycle_start & sdr_region;
            if (issue_q) begin
                req_q <= ~req_q;
            end
        end
    end

    // Payload moves with the toggle and holds until the next one
    always_ff @(posedge clk) begin
        if (issue_q) begin
            addr_q <= next_addr;
            data_q <= cpu.wdata;
            be_q   <= ~cpu.ds_n;
            // ROM is read only
            rw_q   <= region.rom | cpu.rw;
        end
    end

    assign sdr = '{
        addr: addr_q,
        data: data_q,
        be:   be_q,
        rw:   rw_q,
        req:  req_q
    };

    // About to issue, or issued and not yet answered
    assign sdr_busy = (cycle_start & sdr_region) | issue_q | (req_q != sdr_ack);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the bus controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    -Mdir "$BUILD_DIR" --top-module tb_f2_bus_controller -f f2_bus.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_f2_bus_controller" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* testbench/f2_bus_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module f2_bus_checker (
    input wire                        clk,
    input wire                        reset,
    input wire f2_bus_pkg::sdr_req_t  sdr,
    input wire                        sdr_ack,
    input wire                        cycle_start,
    input wire                        dtack_n,
    input wire [2:0]                  ipl_n
);
    int unsigned fail_count = 0;

    ipl_idle_after_reset: assert property (
        @(posedge clk) reset |=> (ipl_n == 3'b111)
    ) else begin
        $error("ipl_n not idle after reset");
        fail_count++;
    end

    // Toggle lands one edge after the start edge
    req_follows_start: assert property (
        @(posedge clk) disable iff (reset)
        (sdr.req != $past(sdr.req)) |-> $past(cycle_start, 2)
    ) else begin
        $error("SDRAM request toggled without a cycle start");
        fail_count++;
    end

    no_dtack_while_pending: assert property (
        @(posedge clk) disable iff (reset)
        (sdr.req != sdr_ack) |-> dtack_n
    ) else begin
        $error("dtack_n low with an SDRAM request outstanding");
        fail_count++;
    end

endmodule

bind f2_bus_controller f2_bus_checker checker_inst (
    .clk         (clk),
    .reset       (reset),
    .sdr         (sdr),
    .sdr_ack     (sdr_ack),
    .cycle_start (cycle_start),
    .dtack_n     (dtack_n),
    .ipl_n       (ipl_n)
);

`default_nettype wire

/* testbench/tb_f2_bus_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_f2_bus_controller;
    import f2_bus_pkg::*;

    localparam int         CLK_PERIOD   = 8;
    localparam int         RESET_CYCLES = 8;
    localparam int         TEST_CYCLES  = 64;
    localparam logic [2:0] FC_DATA      = 3'b101;

    logic           clk;
    logic           reset;
    cpu_bus_t       cpu;
    player_inputs_t inputs;
    logic           vblank_n;
    logic           dma_n;
    sdr_req_t       sdr;
    logic [15:0]    sdr_q;
    logic           sdr_ack;
    logic [15:0]    cpu_rdata;
    logic           dtack_n;
    logic [2:0]     ipl_n;

    // Test table from the data file
    string       t_kind[$];
    logic [23:0] t_addr[$];
    logic [1:0]  t_strobes[$];
    logic [63:0] t_data[$];
    logic [31:0] t_expect[$];

    logic        loaded = 1'b0;
    int          errors = 0;
    int          failed_tests = 0;
    logic        test_ok;
    logic        exp_req = 1'b0;
    sdr_req_t    last_req;
    logic [31:0] rng_state;

    f2_bus_controller f2_bus_controller_inst (
        .clk       (clk),
        .reset     (reset),
        .cpu       (cpu),
        .inputs    (inputs),
        .vblank_n  (vblank_n),
        .dma_n     (dma_n),
        .sdr       (sdr),
        .sdr_q     (sdr_q),
        .sdr_ack   (sdr_ack),
        .cpu_rdata (cpu_rdata),
        .dtack_n   (dtack_n),
        .ipl_n     (ipl_n)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // ROM maps straight through, work RAM keeps its low 16 bits
    function automatic logic [SDR_ADDR_W-1:0] expected_sdr_addr(input logic [23:0] addr);
        if (addr < WORK_BASE) begin
            return CPU_ROM_SDR_BASE + {3'b000, addr};
        end
        return WORK_RAM_SDR_BASE + {11'b0, addr[15:0]};
    endfunction

    ////////////////////////////////////////////////////////////
    // SDRAM model

    initial begin
        logic [2:0] delay;
        sdr_ack   = 1'b0;
        sdr_q     = 16'h0000;
        rng_state = 32'hfba1_50f6;
        forever begin
            @(negedge clk);
            if (!reset && sdr.req != sdr_ack) begin
                rng_state = lcg_next(rng_state);
                delay     = 3'd1 + {1'b0, rng_state[17:16]};
                repeat (delay) @(negedge clk);
                sdr_q   = ~sdr.addr[15:0];
                sdr_ack = sdr.req;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks

    task automatic check_sdr_req(input sdr_req_t got, input sdr_req_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s request %h, expected %h", $time, what, got, exp);
            errors++;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_data(input logic [15:0] got, input logic [15:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s %h, expected %h", $time, what, got, exp);
            errors++;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_ipl(input logic [2:0] got, input logic [2:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: ipl_n %b %s, expected %b", $time, got, what, exp);
            errors++;
            test_ok = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // CPU bus cycle, strobes held until dtack_n

    task automatic bus_cycle(
        input  logic [23:0] addr,
        input  logic [1:0]  strobes,
        input  logic        rw,
        input  logic [2:0]  fc,
        input  logic [15:0] wdata,
        output logic [15:0] rdata,
        output sdr_req_t    req_seen
    );
        logic acked;
        acked    = 1'b0;
        rdata    = '0;
        req_seen = sdr;
        @(negedge clk);
        cpu.addr  = addr;
        cpu.ds_n  = strobes;
        cpu.rw    = rw;
        cpu.fc    = fc;
        cpu.wdata = wdata;
        for (int n = 0; n < 32 && !acked; n++) begin
            @(posedge clk);
            if (!dtack_n) begin
                acked    = 1'b1;
                rdata    = cpu_rdata;
                req_seen = sdr;
            end
        end
        if (!acked) begin
            $display("No data acknowledge for the cycle at address %h", addr);
            errors++;
            test_ok = 1'b0;
        end
        @(negedge clk);
        cpu.ds_n = 2'b11;
        cpu.fc   = FC_DATA;
    endtask

    task automatic load_tests();
        int          fd;
        int          code;
        string       kind;
        string       rest;
        logic [23:0] addr;
        logic [1:0]  strobes;
        logic [63:0] data;
        logic [31:0] exp_v;
        fd = $fopen("f2_bus_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open f2_bus_tests.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", kind);
                if (code == 1 && kind.substr(0, 0) == "#") begin
                    code = $fgets(rest, fd);
                end else if (code == 1) begin
                    code = $fscanf(fd, "%h %h %h %h", addr, strobes, data, exp_v);
                    if (code == 4) begin
                        t_kind.push_back(kind);
                        t_addr.push_back(addr);
                        t_strobes.push_back(strobes);
                        t_data.push_back(data);
                        t_expect.push_back(exp_v);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int i);
        sdr_req_t    exp;
        sdr_req_t    seen;
        logic [15:0] rdata;
        test_ok = 1'b1;
        if (t_kind[i] == "read") begin
            inputs = t_data[i][35:0];
            bus_cycle(t_addr[i], t_strobes[i], 1'b1, FC_DATA, t_data[i][15:0], rdata, seen);
            check_data(rdata, t_expect[i][15:0], "read data");
            if (t_addr[i] < WORK_BASE + WORK_SIZE) begin
                exp_req  = ~exp_req;
                exp      = '{addr: expected_sdr_addr(t_addr[i]), data: t_data[i][15:0],
                             be: ~t_strobes[i], rw: 1'b1, req: exp_req};
                last_req = exp;
                check_sdr_req(seen, exp, "read");
            end
        end else if (t_kind[i] == "write") begin
            bus_cycle(t_addr[i], t_strobes[i], 1'b0, FC_DATA, t_data[i][15:0], rdata, seen);
            if (t_expect[i] != '0) begin
                exp_req  = ~exp_req;
                last_req = '{addr: t_expect[i][SDR_ADDR_W-1:0], data: t_data[i][15:0],
                             be: ~t_strobes[i], rw: 1'b0, req: exp_req};
                check_sdr_req(seen, last_req, "write");
            end else begin
                // Ignored writes leave the last request in place, a stray toggle lands later
                @(negedge clk);
                check_sdr_req(sdr, last_req, "ignored write");
            end
        end else if (t_kind[i] == "iack") begin
            bus_cycle(t_addr[i], t_strobes[i], 1'b1, FC_IACK, 16'h0000, rdata, seen);
            check_ipl(ipl_n, t_expect[i][2:0], "after acknowledge");
        end else if (t_kind[i] == "vbl") begin
            @(negedge clk);
            vblank_n = 1'b0;
            repeat (2) @(negedge clk);
            check_ipl(ipl_n, t_expect[i][2:0], "after vblank");
            vblank_n = 1'b1;
        end else if (t_kind[i] == "dma") begin
            @(negedge clk);
            dma_n = 1'b1;
            repeat (2) @(negedge clk);
            check_ipl(ipl_n, t_expect[i][2:0], "after DMA");
            dma_n = 1'b0;
        end else begin
            $display("Unknown test kind %s in test %0d", t_kind[i], i);
            errors++;
            test_ok = 1'b0;
        end
        if (test_ok) begin
            $display("test %0d %s: ok", i, t_kind[i]);
        end else begin
            $display("test %0d %s: mismatch", i, t_kind[i]);
            failed_tests++;
        end
    endtask

    initial begin
        int checker_fails;
        reset     = 1'b1;
        cpu       = '{addr: '0, ds_n: 2'b11, rw: 1'b1, fc: FC_DATA, wdata: '0};
        inputs    = '0;
        vblank_n  = 1'b1;
        dma_n     = 1'b0;
        load_tests();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);
        for (int i = 0; i < t_kind.size(); i++) begin
            run_test(i);
        end
        checker_fails = f2_bus_controller_inst.checker_inst.fail_count;
        $display("%0d tests run, %0d failed, %0d errors, %0d assertion failures",
                 t_kind.size(), failed_tests, errors, checker_fails);
        if (errors == 0 && checker_fails == 0 && t_kind.size() > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (loaded);
        repeat ((t_kind.size() + 1) * TEST_CYCLES + RESET_CYCLES) @(posedge clk);
        $display("Watchdog expired before all tests finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
